// ==== common/fog_pkg.sv ====
/*
 * Shared definitions for the fiber-optic gyroscope phase-feedback loop.
 * Holds the data widths, the signed sample and phase types, the feedback
 * mode encoding and the packed configuration and DAC word structs.
 * Modules pull it in by a wildcard import in their header.
 */
package fog_pkg;

	// adc sample width
	localparam int ADC_W = 14;
	// phase, step and error width
	localparam int PHASE_W = 32;
	// modulator dac word width
	localparam int DAC_W = 16;
	// gain shift field width, 0..31
	localparam int GAIN_W = 5;

	// raw signed adc sample
	typedef logic signed [ADC_W-1:0] adc_t;

	// phase word, full 32-bit circle
	// wrap in two's complement is the 2pi reset
	typedef logic signed [PHASE_W-1:0] phase_t;

	// feedback mode of the phase ramp
	typedef enum logic [1:0] {
		// loop open, modulation only
		FB_OPEN   = 2'd0,
		// closed loop, ramp scaled by gain_sel
		FB_SHIFT  = 2'd1,
		// closed loop, ramp unscaled
		FB_DIRECT = 2'd2,
		// everything frozen
		FB_HOLD   = 2'd3
	} fb_mode_e;

	// loop configuration from outside, 39 bits
	typedef struct packed {
		fb_mode_e            fb_mode;
		// right shift applied to ramp_pre
		logic [GAIN_W-1:0]   gain_sel;
		// bias modulation depth
		phase_t              mod_amp;
	} loop_cfg_t;

	// word towards the modulator dac, 17 bits
	typedef struct packed {
		// +32767 is +vpi, -32768 is -vpi
		logic signed [DAC_W-1:0] data;
		// one cycle per tau
		logic                    valid;
	} dac_word_t;

endpackage

// ==== rtl/fog_timing.sv ====
/*
 * Transit-time sequencer of the gyroscope loop.
 * Counts TAU_CYCLES clocks per tau and alternates even and odd taus.
 * All loop events are decoded here at fixed counts and handed out as
 * single-cycle strobes, so the other blocks need no counter of their own.
 * Strobes are registered from the next count, so they line up with the
 * count they decode and stay low in reset.
 */
`timescale 1ns/1ps

module fog_timing #(
	parameter int TAU_CYCLES = 16
) (
	input  logic i_clk,
	input  logic i_rst_n,
	output logic o_win_sign,
	output logic o_win_end,
	output logic o_mod_trig,
	output logic o_tau_half,
	output logic o_rate_trig,
	output logic o_ramp_trig
);

	localparam int CNT_W = $clog2(TAU_CYCLES);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TAU_CYCLES - 1);

	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] cnt_nxt;
	// 0 for even tau, 1 for odd tau
	logic             half_q;
	logic             half_nxt;

	// next count, half flips at the tau boundary
	always_comb begin
		if (cnt_q == CNT_LAST) begin
			cnt_nxt  = '0;
			half_nxt = ~half_q;
		end else begin
			cnt_nxt  = cnt_q + 1'b1;
			half_nxt = half_q;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt_q       <= '0;
			half_q      <= 1'b0;
			o_win_end   <= 1'b0;
			o_mod_trig  <= 1'b0;
			o_rate_trig <= 1'b0;
			o_ramp_trig <= 1'b0;
		end else begin
			cnt_q       <= cnt_nxt;
			half_q      <= half_nxt;
			// last count of the odd tau closes the period
			o_win_end   <= (cnt_nxt == CNT_LAST) && half_nxt;
			// start of every tau
			o_mod_trig  <= (cnt_nxt == '0);
			// step is fresh from count 1 on
			o_rate_trig <= (cnt_nxt == CNT_W'(2)) && !half_nxt;
			o_ramp_trig <= (cnt_nxt == CNT_W'(3)) && !half_nxt;
		end
	end

	// demod adds in the even tau, subtracts in the odd one
	assign o_win_sign = ~half_q;
	assign o_tau_half = half_q;

endmodule

// ==== rtl/mod_wave_gen.sv ====
/*
 * Square-wave bias modulation for the phase modulator.
 * On each tau start it registers +mod_amp for an even tau and -mod_amp
 * for an odd tau. The value is picked up by the phase ramp at the next
 * tau start, so the ramp always sees the previous tau's level.
 */
`timescale 1ns/1ps

module mod_wave_gen
	import fog_pkg::*;
(
	input  logic   i_clk,
	input  logic   i_rst_n,
	input  logic   i_mod_trig,
	input  logic   i_tau_half,
	input  phase_t i_mod_amp,
	output phase_t o_mod
);

	phase_t mod_q;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			// zero bias until the first tau start
			mod_q <= '0;
		end else if (i_mod_trig) begin
			// odd tau gets the negative half
			if (i_tau_half) begin
				mod_q <= -i_mod_amp;
			end else begin
				mod_q <= i_mod_amp;
			end
		end
	end

	assign o_mod = mod_q;

endmodule

// ==== demod/fog_demod.sv ====
/*
 * Square-wave demodulator of the Sagnac error.
 * Each valid ADC sample is sign-extended and added during the even tau,
 * subtracted during the odd tau. At the end of the period the sum,
 * including the last sample, is dumped as the error word and the
 * accumulator restarts from zero. err_valid is a one-cycle strobe at
 * count 0 of the following even tau.
 */
`timescale 1ns/1ps

module fog_demod
	import fog_pkg::*;
(
	input  logic   i_clk,
	input  logic   i_rst_n,
	input  adc_t   i_adc,
	input  logic   i_adc_valid,
	input  logic   i_win_sign,
	input  logic   i_win_end,
	output phase_t o_err,
	output logic   o_err_valid
);

	phase_t sample_ext;
	phase_t term;
	phase_t acc_q;
	phase_t acc_sum;
	phase_t err_q;
	logic   err_valid_q;

	// signed size cast keeps the sign
	assign sample_ext = PHASE_W'(i_adc);

	// contribution of this cycle
	always_comb begin
		if (!i_adc_valid) begin
			term = '0;
		end else if (i_win_sign) begin
			term = sample_ext;
		end else begin
			term = -sample_ext;
		end
	end

	// running sum with this cycle's sample
	assign acc_sum = acc_q + term;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			acc_q       <= '0;
			err_q       <= '0;
			err_valid_q <= 1'b0;
		end else begin
			err_valid_q <= i_win_end;
			if (i_win_end) begin
				// dump the full period and start over
				err_q <= acc_sum;
				acc_q <= '0;
			end else begin
				acc_q <= acc_sum;
			end
		end
	end

	// 32 bits hold far more than 2*TAU_CYCLES full-scale samples
	assign o_err       = err_q;
	assign o_err_valid = err_valid_q;

endmodule

// ==== demod/loop_filter.sv ====
/*
 * Integrating loop filter.
 * Every new error word is scaled by 2^-KI_SHIFT and added to the step.
 * The step wraps at 32 bits. It drives the slope of the phase ramp and
 * is also the gyro rate measurement, valid one cycle after the error.
 */
`timescale 1ns/1ps

module loop_filter
	import fog_pkg::*;
#(
	parameter int KI_SHIFT = 2
) (
	input  logic   i_clk,
	input  logic   i_rst_n,
	input  phase_t i_err,
	input  logic   i_err_valid,
	output phase_t o_step,
	output logic   o_step_valid
);

	phase_t err_scaled;
	phase_t step_q;
	logic   step_valid_q;

	// integrator gain, arithmetic so the sign survives
	assign err_scaled = i_err >>> KI_SHIFT;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			step_q       <= '0;
			step_valid_q <= 1'b0;
		end else begin
			step_valid_q <= i_err_valid;
			// once per modulation period
			if (i_err_valid) begin
				step_q <= step_q + err_scaled;
			end
		end
	end

	// step lands at count 1 of the even tau
	assign o_step       = step_q;
	assign o_step_valid = step_valid_q;

endmodule

// ==== phase_ramp/phase_ramp_gen.sv ====
/*
 * Phase ramp generator of the closed loop.
 * Accumulates the rate step into ramp_pre, rescales it by the gain shift
 * into the ramp, and adds the bias modulation into the phase word sent
 * to the DAC stage. Overflow of the 32-bit phase is the 2pi reset.
 * The mode and gain shift are taken from a copy of the configuration
 * that is one clock behind the input.
 */
`timescale 1ns/1ps

module phase_ramp_gen
	import fog_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  loop_cfg_t i_cfg,
	input  logic      i_rate_trig,
	input  logic      i_ramp_trig,
	input  logic      i_mod_trig,
	input  phase_t    i_step,
	input  phase_t    i_mod,
	output phase_t    o_phase
);

	fb_mode_e          fb_mode_q;
	logic [GAIN_W-1:0] gain_sel_q;
	phase_t            ramp_pre_q;
	phase_t            ramp_q;
	phase_t            phase_q;

	// mode and shift, one clock late
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			fb_mode_q  <= FB_OPEN;
			gain_sel_q <= '0;
		end else begin
			fb_mode_q  <= i_cfg.fb_mode;
			gain_sel_q <= i_cfg.gain_sel;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ramp_pre_q <= '0;
			ramp_q     <= '0;
			phase_q    <= '0;
		end else begin
			case (fb_mode_q)
				FB_OPEN: begin
					// no ramp, phase follows the bias only
					ramp_pre_q <= '0;
					ramp_q     <= '0;
					phase_q    <= i_mod;
				end
				FB_SHIFT: begin
					// events never overlap, order kept anyway
					if (i_rate_trig) begin
						// step accumulator
						ramp_pre_q <= ramp_pre_q + i_step;
					end else if (i_ramp_trig) begin
						// scale to the dac vpi span
						ramp_q <= ramp_pre_q >>> gain_sel_q;
					end else if (i_mod_trig) begin
						phase_q <= ramp_q + i_mod;
					end
				end
				FB_DIRECT: begin
					if (i_rate_trig) begin
						ramp_pre_q <= ramp_pre_q + i_step;
					end else if (i_ramp_trig) begin
						// unscaled copy
						ramp_q <= ramp_pre_q;
					end else if (i_mod_trig) begin
						phase_q <= ramp_q + i_mod;
					end
				end
				default: begin
					// FB_HOLD, all three registers freeze
					ramp_pre_q <= ramp_pre_q;
					ramp_q     <= ramp_q;
					phase_q    <= phase_q;
				end
			endcase
		end
	end

	// new phase visible from count 1 of the tau
	assign o_phase = phase_q;

endmodule

// ==== rtl/dac_formatter.sv ====
/*
 * Output stage towards the modulator DAC.
 * The tau start strobe is delayed by one clock to meet the updated phase,
 * then the top DAC_W bits of the phase are registered with a valid
 * strobe, which is high at count 2 of every tau.
 */
`timescale 1ns/1ps

module dac_formatter
	import fog_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  phase_t    i_phase,
	input  logic      i_mod_trig,
	output dac_word_t o_dac
);

	logic      mod_trig_d;
	dac_word_t dac_q;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			mod_trig_d <= 1'b0;
			dac_q      <= '0;
		end else begin
			// phase settles one edge after mod_trig
			mod_trig_d  <= i_mod_trig;
			dac_q.valid <= mod_trig_d;
			if (mod_trig_d) begin
				// top bits, full circle maps to -vpi..+vpi
				dac_q.data <= i_phase[PHASE_W-1 -: DAC_W];
			end
		end
	end

	assign o_dac = dac_q;

endmodule

// ==== rtl/fog_loop_top.sv ====
/*
 * Closed-loop phase-feedback core of the fiber-optic gyroscope.
 * ADC samples are demodulated, integrated into the rate step and turned
 * into a phase ramp plus bias modulation for the modulator DAC. The step
 * is exported as the rate measurement. TAU_CYCLES sets the transit time
 * in clocks, at least 8, and KI_SHIFT the integrator gain.
 */
`timescale 1ns/1ps

module fog_loop_top
	import fog_pkg::*;
#(
	parameter int TAU_CYCLES = 16,
	parameter int KI_SHIFT   = 2
) (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  adc_t      i_adc,
	input  logic      i_adc_valid,
	input  loop_cfg_t i_cfg,
	output dac_word_t o_dac,
	output phase_t    o_rate,
	output logic      o_rate_valid
);

	// sequencer strobes
	logic   win_sign;
	logic   win_end;
	logic   mod_trig;
	logic   tau_half;
	logic   rate_trig;
	logic   ramp_trig;
	// loop data
	phase_t err;
	logic   err_valid;
	phase_t step;
	phase_t mod;
	phase_t phase;

	fog_timing #(
		.TAU_CYCLES (TAU_CYCLES)
	) u_fog_timing (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.o_win_sign  (win_sign),
		.o_win_end   (win_end),
		.o_mod_trig  (mod_trig),
		.o_tau_half  (tau_half),
		.o_rate_trig (rate_trig),
		.o_ramp_trig (ramp_trig)
	);

	fog_demod u_fog_demod (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_adc       (i_adc),
		.i_adc_valid (i_adc_valid),
		.i_win_sign  (win_sign),
		.i_win_end   (win_end),
		.o_err       (err),
		.o_err_valid (err_valid)
	);

	// step doubles as the rate output
	loop_filter #(
		.KI_SHIFT (KI_SHIFT)
	) u_loop_filter (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_err        (err),
		.i_err_valid  (err_valid),
		.o_step       (step),
		.o_step_valid (o_rate_valid)
	);

	mod_wave_gen u_mod_wave_gen (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_mod_trig (mod_trig),
		.i_tau_half (tau_half),
		.i_mod_amp  (i_cfg.mod_amp),
		.o_mod      (mod)
	);

	phase_ramp_gen u_phase_ramp_gen (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_cfg       (i_cfg),
		.i_rate_trig (rate_trig),
		.i_ramp_trig (ramp_trig),
		.i_mod_trig  (mod_trig),
		.i_step      (step),
		.i_mod       (mod),
		.o_phase     (phase)
	);

	dac_formatter u_dac_formatter (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_phase    (phase),
		.i_mod_trig (mod_trig),
		.o_dac      (o_dac)
	);

	assign o_rate = step;

endmodule

// ==== testbench/tb_clk_gen.sv ====
/*
 * Clock and reset source for the gyroscope loop testbench.
 * Free-running clock of PERIOD_NS, reset held low for RESET_CYCLES
 * rising edges and released on a falling edge.
 */
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 8
) (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) o_clk = ~o_clk;
		end
	end

	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		// release away from the sampling edge
		@(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

// ==== testbench/tb_fog_loop.sv ====
/*
 * Testbench of the gyroscope phase-feedback core.
 * Drives random ADC samples and loop configurations on the falling edge,
 * runs a cycle model of the tau counts, demodulator, integrator, ramp
 * and bias modulation next to the DUT, and compares every DAC word and
 * rate word. Phases: open loop, direct, biased direct up to the ramp
 * wrap, shifted, hold, then direct again.
 */
`timescale 1ns/1ps

module tb_fog_loop
	import fog_pkg::*;
;

	localparam int TAU_CYCLES = 16;
	localparam int KI_SHIFT   = 2;
	localparam int RESET_CYC  = 8;
	localparam logic [31:0] SEED = 32'h004a_2ca9;

	// periods per test phase
	localparam int P_OPEN     = 6;
	localparam int P_DIRECT   = 30;
	localparam int P_WRAP     = 360;
	localparam int P_SHIFT    = 8;
	localparam int SHIFT_RUNS = 3;
	localparam int P_HOLD     = 6;
	localparam int P_RESUME   = 10;
	// one alignment period per phase, one spare
	localparam int N_PHASES   = 8;
	localparam int TOTAL_PERIODS = P_OPEN + P_DIRECT + P_WRAP + SHIFT_RUNS * P_SHIFT
		+ P_HOLD + P_RESUME + N_PHASES + 1;
	localparam int TIMEOUT_CYCLES = TOTAL_PERIODS * 2 * TAU_CYCLES + RESET_CYC + 100;

	logic      clk;
	logic      rst_n;
	adc_t      adc;
	logic      adc_valid;
	loop_cfg_t cfg;
	dac_word_t dac;
	phase_t    rate;
	logic      rate_valid;

	int          cycle_count;
	logic [31:0] seed_val;
	bit          bias_adc;
	bit          first_word;

	// model state, values held during the current cycle
	int                m_cnt;
	logic              m_half;
	logic              m_first_tau;
	phase_t            m_acc;
	phase_t            m_err;
	logic              m_err_valid;
	phase_t            m_step;
	phase_t            m_mod;
	fb_mode_e          m_mode;
	logic [GAIN_W-1:0] m_gain;
	phase_t            m_pre;
	phase_t            m_ramp;
	phase_t            m_phase;
	bit                m_wrapped;
	// predicted outputs
	logic                    exp_dac_valid;
	logic signed [DAC_W-1:0] exp_dac_data;
	logic                    exp_rate_valid;
	phase_t                  exp_rate;

	tb_clk_gen #(
		.PERIOD_NS    (40),
		.RESET_CYCLES (RESET_CYC)
	) u_tb_clk_gen (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	fog_loop_top #(
		.TAU_CYCLES (TAU_CYCLES),
		.KI_SHIFT   (KI_SHIFT)
	) u_fog_loop_top (
		.i_clk        (clk),
		.i_rst_n      (rst_n),
		.i_adc        (adc),
		.i_adc_valid  (adc_valid),
		.i_cfg        (cfg),
		.o_dac        (dac),
		.o_rate       (rate),
		.o_rate_valid (rate_valid)
	);

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			stop_on_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h",
				name, actual, expected));
		end
	endtask

	// register contents right after reset
	task automatic reset_model();
		m_cnt          = 0;
		m_half         = 1'b0;
		m_first_tau    = 1'b1;
		m_acc          = '0;
		m_err          = '0;
		m_err_valid    = 1'b0;
		m_step         = '0;
		m_mod          = '0;
		m_mode         = FB_OPEN;
		m_gain         = '0;
		m_pre          = '0;
		m_ramp         = '0;
		m_phase        = '0;
		m_wrapped      = 1'b0;
		exp_dac_valid  = 1'b0;
		exp_dac_data   = '0;
		exp_rate_valid = 1'b0;
		exp_rate       = '0;
	endtask

	// one rising edge, inputs as they stood before it
	task automatic advance_model();
		logic   mod_trig;
		logic   rate_trig;
		logic   ramp_trig;
		logic   win_end;
		phase_t sample;
		phase_t term;
		phase_t pre_sum;
		// tau start is lost in the first tau after reset
		mod_trig  = (m_cnt == 0) && !m_first_tau;
		rate_trig = (m_cnt == 2) && !m_half;
		ramp_trig = (m_cnt == 3) && !m_half;
		win_end   = (m_cnt == TAU_CYCLES - 1) && m_half;

		// dac word taken at count 1, seen at count 2
		exp_dac_valid = (m_cnt == 1) && !m_first_tau;
		if (exp_dac_valid) begin
			exp_dac_data = m_phase[PHASE_W-1 -: DAC_W];
		end

		// ramp follows the delayed mode
		case (m_mode)
			FB_OPEN: begin
				m_pre   = '0;
				m_ramp  = '0;
				m_phase = m_mod;
			end
			FB_SHIFT, FB_DIRECT: begin
				if (rate_trig) begin
					pre_sum = m_pre + m_step;
					// same signs in, other sign out
					if (m_pre[PHASE_W-1] == m_step[PHASE_W-1] &&
						pre_sum[PHASE_W-1] != m_pre[PHASE_W-1]) begin
						m_wrapped = 1'b1;
					end
					m_pre = pre_sum;
				end else if (ramp_trig) begin
					if (m_mode == FB_SHIFT) begin
						m_ramp = m_pre >>> m_gain;
					end else begin
						m_ramp = m_pre;
					end
				end else if (mod_trig) begin
					// previous tau's bias level
					m_phase = m_ramp + m_mod;
				end
			end
			default: begin
			end
		endcase

		// integrator, rate valid one cycle after the error
		exp_rate_valid = m_err_valid;
		if (m_err_valid) begin
			m_step   = m_step + (m_err >>> KI_SHIFT);
			exp_rate = m_step;
		end

		if (mod_trig) begin
			if (m_half) begin
				m_mod = -cfg.mod_amp;
			end else begin
				m_mod = cfg.mod_amp;
			end
		end

		// square-wave detection over one period
		sample = {{(PHASE_W - ADC_W){adc[ADC_W-1]}}, adc};
		if (!adc_valid) begin
			term = '0;
		end else if (!m_half) begin
			term = sample;
		end else begin
			term = -sample;
		end
		if (win_end) begin
			m_err       = m_acc + term;
			m_acc       = '0;
			m_err_valid = 1'b1;
		end else begin
			m_acc       = m_acc + term;
			m_err_valid = 1'b0;
		end

		m_mode = cfg.fb_mode;
		m_gain = cfg.gain_sel;

		if (m_cnt == TAU_CYCLES - 1) begin
			m_cnt       = 0;
			m_half      = ~m_half;
			m_first_tau = 1'b0;
		end else begin
			m_cnt++;
		end
	endtask

	task automatic compare_outputs();
		if (dac.valid !== exp_dac_valid) begin
			if (dac.valid === 1'b1) begin
				stop_on_error($sformatf("unexpected DAC valid strobe at count %0d, half %0d",
					m_cnt, m_half));
			end else begin
				stop_on_error($sformatf("DAC valid strobe missing at count %0d, half %0d",
					m_cnt, m_half));
			end
		end
		if (exp_dac_valid) begin
			check_value("o_dac.data", dac.data, exp_dac_data);
			if (first_word) begin
				// nothing but zero before the first bias level
				check_value("first o_dac.data", dac.data, '0);
				first_word = 1'b0;
			end
		end
		if (rate_valid !== exp_rate_valid) begin
			if (rate_valid === 1'b1) begin
				stop_on_error($sformatf("unexpected rate valid strobe at count %0d, half %0d",
					m_cnt, m_half));
			end else begin
				stop_on_error($sformatf("rate valid strobe missing at count %0d, half %0d",
					m_cnt, m_half));
			end
		end
		if (exp_rate_valid) begin
			check_value("o_rate", rate, exp_rate);
		end
	endtask

	// sample for the cycle now running
	task automatic drive_adc();
		int mag;
		adc_valid = ($urandom % 4) != 0;
		if (bias_adc) begin
			// follows the demod sign so the ramp keeps climbing
			mag = 6144 + ($urandom % 2048);
			if (m_half) begin
				adc = adc_t'(-mag);
			end else begin
				adc = adc_t'(mag);
			end
		end else begin
			adc = adc_t'($urandom);
		end
	endtask

	task automatic run_cycle();
		@(negedge clk);
		advance_model();
		compare_outputs();
		drive_adc();
	endtask

	// new config at count 5 of an even tau, then whole periods
	task automatic run_phase(input fb_mode_e mode, input int periods, input bit bias);
		do begin
			run_cycle();
		end while (!(m_cnt == 5 && !m_half));
		cfg.fb_mode  = mode;
		cfg.gain_sel = GAIN_W'($urandom_range(0, 15));
		cfg.mod_amp  = phase_t'($urandom);
		bias_adc     = bias;
		repeat (periods * 2 * TAU_CYCLES) begin
			run_cycle();
		end
	endtask

	// run limit
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			stop_on_error($sformatf("timeout after %0d cycles without reaching the end",
				cycle_count));
		end
	end

	initial begin
		seed_val    = $urandom(SEED);
		adc         = '0;
		adc_valid   = 1'b0;
		cfg         = '0;
		bias_adc    = 1'b0;
		first_word  = 1'b1;
		cycle_count = 0;
		reset_model();

		// strobes stay low in reset
		repeat (6) begin
			@(negedge clk);
			if (dac.valid !== 1'b0 || rate_valid !== 1'b0) begin
				stop_on_error("valid strobe high while reset is asserted");
			end
		end
		@(posedge rst_n);
		drive_adc();

		run_phase(FB_OPEN, P_OPEN, 1'b0);
		run_phase(FB_DIRECT, P_DIRECT, 1'b0);
		run_phase(FB_DIRECT, P_WRAP, 1'b1);
		if (!m_wrapped) begin
			stop_on_error("ramp accumulator never wrapped in the biased run");
		end
		repeat (SHIFT_RUNS) begin
			run_phase(FB_SHIFT, P_SHIFT, 1'b0);
		end
		run_phase(FB_HOLD, P_HOLD, 1'b0);
		// resumes from the frozen ramp
		run_phase(FB_DIRECT, P_RESUME, 1'b0);

		$display("sim passed");
		$finish;
	end

endmodule

// ==== fog_loop.f ====
common/fog_pkg.sv
rtl/fog_timing.sv
rtl/mod_wave_gen.sv
demod/fog_demod.sv
demod/loop_filter.sv
phase_ramp/phase_ramp_gen.sv
rtl/dac_formatter.sv
rtl/fog_loop_top.sv
testbench/tb_clk_gen.sv
testbench/tb_fog_loop.sv

// ==== Bender.yml ====
package:
  name: fog_loop

sources:
  # design, compile order
  - common/fog_pkg.sv
  - rtl/fog_timing.sv
  - rtl/mod_wave_gen.sv
  - demod/fog_demod.sv
  - demod/loop_filter.sv
  - phase_ramp/phase_ramp_gen.sv
  - rtl/dac_formatter.sv
  - rtl/fog_loop_top.sv

  # testbench
  - target: simulation
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_fog_loop.sv
